// ==== compile.f ====
rtl/intExecPkg.sv
rtl/intAlu.sv
rtl/intShifter.sv
rtl/branchResolver.sv
rtl/intOpDecoder.sv
rtl/intExecStage.sv
rtl/resultStage.sv
rtl/intExecUnit.sv
testbench/tbClock.sv
testbench/tbIntExecUnit.sv

// ==== rtl/branchResolver.sv ====
// Branch resolution for the execute stage
// Evaluates the condition, picks the next address and flags mispredictions

module branchResolver import intExecPkg::*; (
    input  DecodedOp op,
    output logic     condTrue,
    output logic     taken,
    output logic     mispred,
    output DataPath  nextAddr
);

    logic    isBranch;
    DataPath target;

    always_comb begin
        case (CondCode'(op.subCode))
            COND_EQ:  condTrue = (op.opA == op.opB);
            COND_NE:  condTrue = (op.opA != op.opB);
            COND_LT:  condTrue = ($signed(op.opA) < $signed(op.opB));
            COND_LTU: condTrue = (op.opA < op.opB);
            COND_GE:  condTrue = ($signed(op.opA) >= $signed(op.opB));
            COND_GEU: condTrue = (op.opA >= op.opB);
            COND_AL:  condTrue = 1'b1;
            COND_NV:  condTrue = 1'b0;
            default:  condTrue = 1'b1;
        endcase
    end

    assign isBranch = (op.opType == OP_BR) || (op.opType == OP_RIJ);

    // BR with AL is a plain jump, RIJ always jumps
    assign taken = ((op.opType == OP_BR) && condTrue) || (op.opType == OP_RIJ);

    // Register-indirect target has bit 0 cleared
    assign target = (op.opType == OP_RIJ) ? ((op.opA + op.disp) & ~DataPath'(1))
                                          : (op.pc + op.disp);

    assign nextAddr = taken ? target : op.pc + DataPath'(INSN_BYTES);

    assign mispred = op.valid && isBranch &&
                     ((op.predTaken != taken) || (taken && (op.predAddr != nextAddr)));

endmodule

// ==== rtl/intAlu.sv ====
// Combinational integer ALU
// Add, subtract, bitwise logic and set-less-than on two operands

module intAlu import intExecPkg::*; (
    input  AluCode  aluCode,
    input  DataPath opA,
    input  DataPath opB,
    output DataPath aluOut
);

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluCode)
            ALU_ADD:  aluOut = opA + opB;
            ALU_SUB:  aluOut = opA - opB;
            ALU_AND:  aluOut = opA & opB;
            ALU_OR:   aluOut = opA | opB;
            ALU_XOR:  aluOut = opA ^ opB;
            // Compare results are 1 or 0
            ALU_SLT:  aluOut = DataPath'(ltSigned);
            ALU_SLTU: aluOut = DataPath'(ltUnsigned);
            default:  aluOut = '0;
        endcase
    end

endmodule

// ==== rtl/intExecPkg.sv ====
// Shared types and constants for the integer execution slice
// Imported by every RTL module that handles micro-ops or data words

package intExecPkg;

    localparam int DATA_WIDTH = 32;
    localparam int INSN_BYTES = 4;
    localparam int IMM_WIDTH = 16;
    localparam int SHAMT_WIDTH = 5;

    typedef logic [DATA_WIDTH-1:0] DataPath;

    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_SHIFT  = 3'd1,
        OP_SELECT = 3'd2,
        OP_BR     = 3'd3,
        OP_RIJ    = 3'd4
    } IntOpType;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6
    } AluCode;

    typedef enum logic [3:0] {
        SHIFT_SLL = 4'd0,
        SHIFT_SRL = 4'd1,
        SHIFT_SRA = 4'd2
    } ShiftType;

    // Codes outside this list evaluate as true
    typedef enum logic [3:0] {
        COND_EQ  = 4'd0,
        COND_NE  = 4'd1,
        COND_LT  = 4'd2,
        COND_LTU = 4'd3,
        COND_GE  = 4'd4,
        COND_GEU = 4'd5,
        COND_AL  = 4'd6,
        COND_NV  = 4'd7
    } CondCode;

    // Micro-op word with opType in the top bits
    typedef struct packed {
        IntOpType                     opType;
        logic [3:0]                   subCode;
        logic                         immSelB;
        logic [7:0]                   reserved;
        logic signed [IMM_WIDTH-1:0]  imm;
    } MicroOp;

    typedef struct packed {
        logic       valid;
        IntOpType   opType;
        logic [3:0] subCode;
        DataPath    pc;
        DataPath    opA;
        DataPath    opB;
        DataPath    disp;
        logic       predTaken;
        DataPath    predAddr;
    } DecodedOp;

endpackage

// ==== rtl/intExecStage.sv ====
// Execute stage of the execution slice
// Runs ALU, shifter and branch resolver, then registers the chosen result

module intExecStage import intExecPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     squash,
    input  DecodedOp decOp,
    output logic     exValid,
    output logic     exIsBranch,
    output logic     exTaken,
    output logic     exMispred,
    output DataPath  exData,
    output DataPath  exNextAddr
);

    DataPath aluOut;
    DataPath shiftOut;
    DataPath nextAddr;
    DataPath dataOut;
    logic    condTrue;
    logic    taken;
    logic    mispred;
    logic    isBranch;

    intAlu u_intAlu (
        .aluCode (AluCode'(decOp.subCode)),
        .opA     (decOp.opA),
        .opB     (decOp.opB),
        .aluOut  (aluOut)
    );

    // Amount comes from opB, already replaced by the immediate if selected
    intShifter u_intShifter (
        .shiftType (ShiftType'(decOp.subCode)),
        .dataIn    (decOp.opA),
        .amount    (decOp.opB[SHAMT_WIDTH-1:0]),
        .dataOut   (shiftOut)
    );

    branchResolver u_branchResolver (
        .op       (decOp),
        .condTrue (condTrue),
        .taken    (taken),
        .mispred  (mispred),
        .nextAddr (nextAddr)
    );

    assign isBranch = (decOp.opType == OP_BR) || (decOp.opType == OP_RIJ);

    always_comb begin
        case (decOp.opType)
            OP_ALU:        dataOut = aluOut;
            OP_SHIFT:      dataOut = shiftOut;
            // Link value for branches
            OP_BR, OP_RIJ: dataOut = decOp.pc + DataPath'(INSN_BYTES);
            default:       dataOut = condTrue ? decOp.opA : decOp.opB;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else if (!stall) begin
            exValid <= decOp.valid && !squash;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exData     <= dataOut;
            exIsBranch <= isBranch;
            exTaken    <= taken;
            exNextAddr <= nextAddr;
            exMispred  <= mispred;
        end
    end

endmodule

// ==== rtl/intExecUnit.sv ====
// Top level of the in-order integer execution slice
// Decode, execute and result stages, three cycles from input to output

module intExecUnit import intExecPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    inValid,
    input  logic    inPredTaken,
    input  MicroOp  inOp,
    input  DataPath inPc,
    input  DataPath inOpA,
    input  DataPath inOpB,
    input  DataPath inPredAddr,
    output logic    resValid,
    output logic    resIsBranch,
    output logic    resTaken,
    output logic    resMispred,
    output DataPath resData,
    output DataPath resNextAddr
);

    DecodedOp decOp;
    logic     squash;
    logic     exValid;
    logic     exIsBranch;
    logic     exTaken;
    logic     exMispred;
    DataPath  exData;
    DataPath  exNextAddr;

    intOpDecoder u_intOpDecoder (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .squash      (squash),
        .inValid     (inValid),
        .inOp        (inOp),
        .inPc        (inPc),
        .inOpA       (inOpA),
        .inOpB       (inOpB),
        .inPredAddr  (inPredAddr),
        .inPredTaken (inPredTaken),
        .decOp       (decOp)
    );

    intExecStage u_intExecStage (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .squash     (squash),
        .decOp      (decOp),
        .exValid    (exValid),
        .exIsBranch (exIsBranch),
        .exTaken    (exTaken),
        .exMispred  (exMispred),
        .exData     (exData),
        .exNextAddr (exNextAddr)
    );

    resultStage u_resultStage (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .exValid     (exValid),
        .exIsBranch  (exIsBranch),
        .exTaken     (exTaken),
        .exMispred   (exMispred),
        .exData      (exData),
        .exNextAddr  (exNextAddr),
        .squash      (squash),
        .resValid    (resValid),
        .resIsBranch (resIsBranch),
        .resTaken    (resTaken),
        .resMispred  (resMispred),
        .resData     (resData),
        .resNextAddr (resNextAddr)
    );

endmodule

// ==== rtl/intOpDecoder.sv ====
// Decode stage of the execution slice
// Splits the incoming micro-op and registers it for the execute stage

module intOpDecoder import intExecPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     squash,
    input  logic     inValid,
    input  MicroOp   inOp,
    input  DataPath  inPc,
    input  DataPath  inOpA,
    input  DataPath  inOpB,
    input  DataPath  inPredAddr,
    input  logic     inPredTaken,
    output DecodedOp decOp
);

    DecodedOp nextOp;
    DecodedOp payloadReg;
    logic     validReg;

    always_comb begin
        nextOp           = '0;
        nextOp.opType    = inOp.opType;
        nextOp.subCode   = inOp.subCode;
        nextOp.pc        = inPc;
        nextOp.opA       = inOpA;
        // Immediate is sign-extended to full width
        nextOp.disp      = {{(DATA_WIDTH-IMM_WIDTH){inOp.imm[IMM_WIDTH-1]}}, inOp.imm};
        nextOp.opB       = inOp.immSelB ? nextOp.disp : inOpB;
        nextOp.predTaken = inPredTaken;
        nextOp.predAddr  = inPredAddr;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validReg <= 1'b0;
        end else if (!stall) begin
            // Op behind a mispredicted branch is dropped here
            validReg <= inValid && !squash;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            payloadReg <= nextOp;
        end
    end

    always_comb begin
        decOp       = payloadReg;
        decOp.valid = validReg;
    end

endmodule

// ==== rtl/intShifter.sv ====
// Combinational shifter
// Logical left, logical right and arithmetic right by a 5-bit amount

module intShifter import intExecPkg::*; (
    input  ShiftType               shiftType,
    input  DataPath                dataIn,
    input  logic [SHAMT_WIDTH-1:0] amount,
    output DataPath                dataOut
);

    DataPath sraOut;

    // Sign bit fills from the left
    assign sraOut = DataPath'($signed(dataIn) >>> amount);

    always_comb begin
        case (shiftType)
            SHIFT_SLL: dataOut = dataIn << amount;
            SHIFT_SRL: dataOut = dataIn >> amount;
            SHIFT_SRA: dataOut = sraOut;
            default:   dataOut = dataIn;
        endcase
    end

endmodule

// ==== rtl/resultStage.sv ====
// Result stage of the execution slice
// Holds the output register and raises squash for a mispredicted branch

module resultStage import intExecPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    exValid,
    input  logic    exIsBranch,
    input  logic    exTaken,
    input  logic    exMispred,
    input  DataPath exData,
    input  DataPath exNextAddr,
    output logic    squash,
    output logic    resValid,
    output logic    resIsBranch,
    output logic    resTaken,
    output logic    resMispred,
    output DataPath resData,
    output DataPath resNextAddr
);

    logic validReg;

    // Branch entering this stage kills the two younger ops
    assign squash = exValid && exMispred && !stall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validReg <= 1'b0;
        end else if (!stall) begin
            validReg <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            resData     <= exData;
            resIsBranch <= exIsBranch;
            resTaken    <= exTaken;
            resNextAddr <= exNextAddr;
            resMispred  <= exMispred;
        end
    end

    // Held result is reported only once
    assign resValid = validReg && !stall;

endmodule

// ==== testbench/intExecStim.txt ====
# name stall op pc opA opB predTaken predAddr expData expTaken expNextAddr expMispred
# Fields after the name are hex; stall 1 holds the op under stall for two cycles first
addReg 0 00000000 00001000 00000005 00000007 0 00000000 0000000c 0 00001004 0
addImmNeg 0 0100fff6 00001004 00000005 00000000 0 00000000 fffffffb 0 00001008 0
subReg 1 02000000 00001008 00000003 00000005 0 00000000 fffffffe 0 0000100c 0
andImm 0 050000f0 0000100c 12345678 00000000 0 00000000 00000070 0 00001010 0
orReg 0 06000000 00001010 f0000000 0000000f 0 00000000 f000000f 0 00001014 0
xorImmNeg 0 0900ffff 00001014 0f0f0f0f 00000000 0 00000000 f0f0f0f0 0 00001018 0
sltReg 0 0a000000 00001018 ffffffff 00000001 0 00000000 00000001 0 0000101c 0
sltuReg 0 0c000000 0000101c ffffffff 00000001 0 00000000 00000000 0 00001020 0
sltuImmNeg 0 0d008000 00001020 00000005 00000000 0 00000000 00000001 0 00001024 0
sllImm 0 21000004 00001024 0000000f 00000000 0 00000000 000000f0 0 00001028 0
srlReg 0 22000000 00001028 80000000 ffffffe4 0 00000000 08000000 0 0000102c 0
sraImmNeg 1 25000008 0000102c 80000000 00000000 0 00000000 ff800000 0 00001030 0
sraRegNeg 0 24000000 00001030 fffffff0 00000002 0 00000000 fffffffc 0 00001034 0
selEqFalse 0 40000000 00001034 00000001 00000002 0 00000000 00000002 0 00001038 0
selNeTrue 0 42000000 00001038 00000001 00000002 0 00000000 00000001 0 0000103c 0
selLtTrue 0 44000000 0000103c ffffffff 00000001 0 00000000 ffffffff 0 00001040 0
selLtuFalse 0 46000000 00001040 ffffffff 00000001 0 00000000 00000001 0 00001044 0
selGeTrue 0 48000000 00001044 00000001 ffffffff 0 00000000 00000001 0 00001048 0
selGeuFalse 0 4a000000 00001048 00000001 ffffffff 0 00000000 ffffffff 0 0000104c 0
selAl 0 4c000000 0000104c aaaaaaaa 55555555 0 00000000 aaaaaaaa 0 00001050 0
brEqTaken 0 60000040 00002000 00000005 00000005 1 00002040 00002004 1 00002040 0
brNeNotTaken 0 6200fff0 00002100 00000007 00000007 0 00000000 00002104 0 00002104 0
brAlBack 1 6c00fff0 00003000 00000000 00000000 1 00002ff0 00003004 1 00002ff0 0
rijTaken 0 80000011 00001200 00004000 00000000 1 00004010 00001204 1 00004010 0
brLtWrongDir 0 64000020 00005000 ffffffff 00000001 0 00000000 00005004 1 00005020 1
sqAdd 0 00000000 00005004 00000001 00000001 0 00000000 00000002 0 00005008 0
sqSub 0 02000000 00005008 00000009 00000001 0 00000000 00000008 0 0000500c 0
afterDir 0 00000000 00005020 00000010 00000020 0 00000000 00000030 0 00005024 0
rijWrongTgt 0 80000000 00001300 00006000 00000000 1 00006100 00001304 1 00006000 1
sqStallAnd 1 04000000 00001304 ffffffff 0000000f 0 00000000 0000000f 0 00001308 0
sqOr 0 06000000 00001308 00000001 00000002 0 00000000 00000003 0 0000130c 0
afterTgt 0 0a000000 00006000 00000001 00000002 0 00000000 00000001 0 00006004 0

// ==== testbench/tbClock.sv ====
// Free-running clock for the testbench
// 10 ns period starting low

module tbClock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // Half period of 5 ns
    always #5 clk = ~clk;

endmodule

// ==== testbench/tbIntExecUnit.sv ====
// Testbench for the integer execution slice
// Reads ops and expected results from testbench/intExecStim.txt, drives the DUT
// and checks every result in order, skipping ops killed by a misprediction

module tbIntExecUnit import intExecPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic    clk;
    logic    arstN;
    logic    stall;
    logic    inValid;
    logic    inPredTaken;
    MicroOp  inOp;
    DataPath inPc;
    DataPath inOpA;
    DataPath inOpB;
    DataPath inPredAddr;
    logic    resValid;
    logic    resIsBranch;
    logic    resTaken;
    logic    resMispred;
    DataPath resData;
    DataPath resNextAddr;

    // Stimulus lines and the fields of the line being driven
    string   stimLines[$];
    string   testName;
    DataPath stallFlag;
    DataPath opWord;
    DataPath pcVal;
    DataPath opAVal;
    DataPath opBVal;
    DataPath predTakenVal;
    DataPath predAddrVal;
    DataPath expDataVal;
    DataPath expTakenVal;
    DataPath expNextVal;
    DataPath expMispredVal;

    // Expected results of surviving ops in program order
    string   expName[$];
    DataPath expData[$];
    logic    expBranch[$];
    logic    expTaken[$];
    DataPath expNext[$];
    logic    expMispred[$];

    int squashSlots = 0;
    int pushedCount = 0;
    int resultCount = 0;
    int cycleCount = 0;
    int cycleLimit = 50;

    tbClock u_tbClock (
        .clk (clk)
    );

    intExecUnit u_intExecUnit (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .inValid     (inValid),
        .inPredTaken (inPredTaken),
        .inOp        (inOp),
        .inPc        (inPc),
        .inOpA       (inOpA),
        .inOpB       (inOpB),
        .inPredAddr  (inPredAddr),
        .resValid    (resValid),
        .resIsBranch (resIsBranch),
        .resTaken    (resTaken),
        .resMispred  (resMispred),
        .resData     (resData),
        .resNextAddr (resNextAddr)
    );

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkField(input string name, input string field,
                              input DataPath expected, input DataPath actual);
        assert (actual === expected) else begin
            stopWithFailure($sformatf("mismatch %s %s: expected %h actual %h",
                                      name, field, expected, actual));
        end
    endtask

    task automatic readStimulus();
        int    fd;
        string line;
        fd = $fopen("testbench/intExecStim.txt", "r");
        if (fd == 0) begin
            stopWithFailure("cannot open the stimulus file testbench/intExecStim.txt");
        end
        while ($fgets(line, fd) > 0) begin
            // Skip blank lines and comments
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                stimLines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic applyOp(input logic stallBit);
        inValid     = 1'b1;
        stall       = stallBit;
        inOp        = MicroOp'(opWord);
        inPc        = pcVal;
        inOpA       = opAVal;
        inOpB       = opBVal;
        inPredTaken = predTakenVal[0];
        inPredAddr  = predAddrVal;
    endtask

    // Called for each op taken in on an edge without stall
    task automatic recordAccepted();
        logic squashed;
        squashed = (squashSlots > 0);
        if (squashed) begin
            squashSlots--;
        end else begin
            expName.push_back(testName);
            expData.push_back(expDataVal);
            expBranch.push_back((inOp.opType == OP_BR) || (inOp.opType == OP_RIJ));
            expTaken.push_back(expTakenVal[0]);
            expNext.push_back(expNextVal);
            expMispred.push_back(expMispredVal[0]);
            pushedCount++;
            // Two younger ops die behind a mispredicted branch
            if (expMispredVal[0]) begin
                squashSlots = 2;
            end
        end
    endtask

    initial begin
        int fields;
        int idle;
        arstN       = 1'b0;
        stall       = 1'b0;
        inValid     = 1'b0;
        inPredTaken = 1'b0;
        inOp        = '0;
        inPc        = '0;
        inOpA       = '0;
        inOpB       = '0;
        inPredAddr  = '0;
        void'($urandom(5));
        readStimulus();
        cycleLimit = 4 * stimLines.size() + 50;
        repeat (8) @(negedge clk);
        arstN = 1'b1;
        foreach (stimLines[i]) begin
            fields = $sscanf(stimLines[i], "%s %h %h %h %h %h %h %h %h %h %h %h",
                             testName, stallFlag, opWord, pcVal, opAVal, opBVal,
                             predTakenVal, predAddrVal, expDataVal, expTakenVal,
                             expNextVal, expMispredVal);
            if (fields != 12) begin
                stopWithFailure($sformatf("stimulus line %0d has %0d fields instead of 12",
                                          i + 1, fields));
            end
            // No idle gap inside a squash window, so the two ops behind it are killed
            if (squashSlots == 0) begin
                idle = $urandom % 2;
                repeat (idle) begin
                    @(negedge clk);
                    inValid = 1'b0;
                    stall   = 1'b0;
                end
            end
            if (stallFlag[0]) begin
                repeat (2) begin
                    @(negedge clk);
                    applyOp(1'b1);
                end
            end
            @(negedge clk);
            applyOp(1'b0);
            recordAccepted();
        end
        @(negedge clk);
        inValid = 1'b0;
        stall   = 1'b0;
        while (resultCount < pushedCount) begin
            @(posedge clk);
        end
        // A leaked squashed op would surface within these cycles
        repeat (4) @(posedge clk);
        if (resultCount == pushedCount) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stopWithFailure($sformatf("%0d results seen but %0d expected",
                                      resultCount, pushedCount));
        end
    end

    // Result monitor sampling outputs settled before the rising edge
    always @(posedge clk) begin
        if (arstN && resValid) begin
            if (expName.size() == 0) begin
                stopWithFailure($sformatf("unexpected result with data %h, no op outstanding",
                                          resData));
            end else begin
                checkField(expName[0], "data", expData[0], resData);
                checkField(expName[0], "isBranch", DataPath'(expBranch[0]),
                           DataPath'(resIsBranch));
                checkField(expName[0], "taken", DataPath'(expTaken[0]), DataPath'(resTaken));
                checkField(expName[0], "nextAddr", expNext[0], resNextAddr);
                checkField(expName[0], "mispred", DataPath'(expMispred[0]),
                           DataPath'(resMispred));
                void'(expName.pop_front());
                void'(expData.pop_front());
                void'(expBranch.pop_front());
                void'(expTaken.pop_front());
                void'(expNext.pop_front());
                void'(expMispred.pop_front());
                resultCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("timeout after %0d cycles with %0d results outstanding",
                                      cycleCount, pushedCount - resultCount));
        end
    end

endmodule
